/* Makefile */
# Verilator build and run of the ALU core testbench
# make sim fails unless the run prints the pass message

VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps
TOP       = AluCore_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/AdderSetUnit.sv */
//--------------------------------------------------------------------------
// Arithmetic half of the ALU datapath
// One carry adder serves ADD and SUB, the set path loads an immediate
// Purely combinational, carry is produced for every opcode
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module AdderSetUnit (
	// Operation select
	input  aluOpPkg::aluOp_e        i_opCode,
	input  logic                    i_opSel,   // Set: shift immediate in under srcB
	// Operands
	input  logic [`ALU_DATA_W-1:0]  i_srcA,
	input  logic [`ALU_DATA_W-1:0]  i_srcB,
	// Results
	output logic [`ALU_DATA_W-1:0]  o_arithResult,
	output logic                    o_carry    // Adder carry-out
);

	localparam int halfW = `ALU_DATA_W / 2; // Byte lane width for set

	//----------------------------------------------------------------------
	// Internal signals
	//----------------------------------------------------------------------

	logic [`ALU_DATA_W-1:0] adderA;      // srcA, inverted for SUB
	logic                   adderCin;    // +1 completes the two's complement
	logic [`ALU_DATA_W:0]   adderFull;   // Sum with carry on top
	logic [`ALU_DATA_W-1:0] setResult;

	//----------------------------------------------------------------------
	// Adder
	//----------------------------------------------------------------------

	// Opcode bit 0 separates SUB from ADD
	assign adderA   = i_srcA ^ {`ALU_DATA_W{i_opCode[0]}};
	assign adderCin = i_opCode[0];

	// srcB + ~srcA + 1 gives srcB - srcA
	assign adderFull = {1'b0, i_srcB} + {1'b0, adderA} + {{`ALU_DATA_W{1'b0}}, adderCin};

	assign o_carry = adderFull[`ALU_DATA_W]; // Valid even for non-arith ops

	//----------------------------------------------------------------------
	// Set (load immediate)
	//----------------------------------------------------------------------

	always_comb begin
		if (i_opSel) begin
			// Byte of srcA moves up, srcB low byte stays underneath
			setResult = {i_srcA[halfW-1:0], i_srcB[halfW-1:0]};
		end else begin
			setResult = i_srcB;                         // Whole immediate
		end
	end

	//----------------------------------------------------------------------
	// Output select
	//----------------------------------------------------------------------

	always_comb begin
		if (i_opCode == aluOpPkg::OP_SET) begin
			o_arithResult = setResult;
		end else begin
			o_arithResult = adderFull[`ALU_DATA_W-1:0]; // ADD/SUB (and don't-care ops)
		end
	end

endmodule

/* logic/AluCore.sv */
//--------------------------------------------------------------------------
// Top level of the execution unit
// Four-phase req/ack wrapper around the adder/set and bitwise units
// Operands are latched on an accepted req, the result is registered one
// edge later and held with ack high until req drops
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module AluCore (
	input  logic                    i_clk,
	input  logic                    i_rstN,    // Async, active low
	// Request side, fields stable while i_req is high
	input  logic                    i_req,
	input  aluOpPkg::aluOp_e        i_opCode,
	input  logic                    i_opSel,
	input  logic [`ALU_DATA_W-1:0]  i_srcA,
	input  logic [`ALU_DATA_W-1:0]  i_srcB,
	// Response side, valid while o_ack is high
	output logic                    o_ack,
	output logic [`ALU_DATA_W-1:0]  o_result,
	output logic [`ALU_CC_W-1:0]    o_ccodes
);

	//----------------------------------------------------------------------
	// Internal signals
	//----------------------------------------------------------------------

	aluFlowPkg::hsState_e    hsState;       // Handshake FSM

	// Latched request
	aluOpPkg::aluOp_e        opCodeReg;
	logic                    opSelReg;
	logic [`ALU_DATA_W-1:0]  srcAReg;
	logic [`ALU_DATA_W-1:0]  srcBReg;

	// Unit outputs
	logic [`ALU_DATA_W-1:0]  arithResult;
	logic [`ALU_DATA_W-1:0]  logicResult;
	logic                    adderCarry;
	logic [`ALU_DATA_W-1:0]  mergeResult;
	logic [`ALU_CC_W-1:0]    mergeCcodes;

	logic                    accept;        // req seen in IDLE

	assign accept = (hsState == aluFlowPkg::ST_IDLE) && i_req;

	//----------------------------------------------------------------------
	// Handshake FSM and output registers
	//----------------------------------------------------------------------

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			hsState  <= aluFlowPkg::ST_IDLE;
			o_ack    <= 1'b0;
			o_result <= '0;
			o_ccodes <= '0;
		end else begin
			case (hsState)
				aluFlowPkg::ST_IDLE: begin
					if (i_req) hsState <= aluFlowPkg::ST_EXEC; // Operands latched below
				end
				aluFlowPkg::ST_EXEC: begin
					// Operands settled through the units, capture
					o_result <= mergeResult;
					o_ccodes <= mergeCcodes;
					o_ack    <= 1'b1;
					hsState  <= aluFlowPkg::ST_ACK;
				end
				aluFlowPkg::ST_ACK: begin
					if (!i_req) begin              // Requester done, release
						o_ack   <= 1'b0;
						hsState <= aluFlowPkg::ST_IDLE;
					end
				end
				default: hsState <= aluFlowPkg::ST_IDLE;
			endcase
		end
	end

	// Request fields, loaded only on accept
	always_ff @(posedge i_clk) begin
		if (accept) begin
			opCodeReg <= i_opCode;
			opSelReg  <= i_opSel;
			srcAReg   <= i_srcA;
			srcBReg   <= i_srcB;
		end
	end

	//----------------------------------------------------------------------
	// Datapath units
	//----------------------------------------------------------------------

	AdderSetUnit uAdderSet (
		.i_opCode      (opCodeReg),
		.i_opSel       (opSelReg),
		.i_srcA        (srcAReg),
		.i_srcB        (srcBReg),
		.o_arithResult (arithResult),
		.o_carry       (adderCarry)
	);

	BitwiseUnit uBitwise (
		.i_opCode      (opCodeReg),
		.i_srcA        (srcAReg),
		.i_srcB        (srcBReg),
		.o_logicResult (logicResult)
	);

	// Picks between the two, builds n/z/p/c
	ResultMerge uMerge (
		.i_opCode      (opCodeReg),
		.i_arithResult (arithResult),
		.i_logicResult (logicResult),
		.i_carry       (adderCarry),
		.o_result      (mergeResult),
		.o_ccodes      (mergeCcodes)
	);

endmodule

/* logic/BitwiseUnit.sv */
//--------------------------------------------------------------------------
// Logic half of the ALU datapath
// AND, OR, XOR and logical shifts of srcA, picked by opcode
// Arithmetic opcodes fall back to XOR, the merge ignores that output
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module BitwiseUnit (
	input  aluOpPkg::aluOp_e        i_opCode,
	input  logic [`ALU_DATA_W-1:0]  i_srcA,
	input  logic [`ALU_DATA_W-1:0]  i_srcB,     // Also carries shift amount
	output logic [`ALU_DATA_W-1:0]  o_logicResult
);

	logic [`ALU_DATA_W-1:0]  andResult, orResult, xorResult;
	logic [`ALU_DATA_W-1:0]  sllResult, srlResult;
	logic [`ALU_SHAMT_W-1:0] shamt;

	// Bitwise ops
	assign andResult = i_srcA & i_srcB;
	assign orResult  = i_srcA | i_srcB;
	assign xorResult = i_srcA ^ i_srcB;

	// Shifts, zero fill both ways
	assign shamt     = i_srcB[`ALU_SHAMT_W-1:0];
	assign sllResult = i_srcA << shamt;
	assign srlResult = i_srcA >> shamt;

	//----------------------------------------------------------------------
	// Result select
	//----------------------------------------------------------------------

	always_comb begin
		case (i_opCode)
			aluOpPkg::OP_AND: o_logicResult = andResult;
			aluOpPkg::OP_OR:  o_logicResult = orResult;
			aluOpPkg::OP_SLL: o_logicResult = sllResult;
			aluOpPkg::OP_SRL: o_logicResult = srlResult;
			default:          o_logicResult = xorResult; // OP_XOR, rest unused
		endcase
	end

endmodule

/* logic/ResultMerge.sv */
//--------------------------------------------------------------------------
// Final result select and condition-code generation
// Arithmetic unit output for ADD/SUB/SET, logic unit output otherwise
// n/z/p follow the chosen result, c is always the adder carry
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module ResultMerge (
	input  aluOpPkg::aluOp_e        i_opCode,
	// Unit outputs
	input  logic [`ALU_DATA_W-1:0]  i_arithResult,
	input  logic [`ALU_DATA_W-1:0]  i_logicResult,
	input  logic                    i_carry,
	// Merged outputs
	output logic [`ALU_DATA_W-1:0]  o_result,
	output logic [`ALU_CC_W-1:0]    o_ccodes
);

	logic useArith; // High for the three adder/set opcodes

	//----------------------------------------------------------------------
	// Result select
	//----------------------------------------------------------------------

	always_comb begin
		case (i_opCode)
			aluOpPkg::OP_ADD,
			aluOpPkg::OP_SUB,
			aluOpPkg::OP_SET: useArith = 1'b1;
			default:          useArith = 1'b0;
		endcase
	end

	assign o_result = useArith ? i_arithResult : i_logicResult;

	//----------------------------------------------------------------------
	// Condition codes
	//----------------------------------------------------------------------

	always_comb begin
		o_ccodes                  = '0;
		o_ccodes[aluOpPkg::CC_N]  = o_result[`ALU_DATA_W-1];   // Sign bit
		o_ccodes[aluOpPkg::CC_Z]  = ~(|o_result);              // All zero
		o_ccodes[aluOpPkg::CC_P]  = ~o_result[`ALU_DATA_W-1];  // Set on zero too
		o_ccodes[aluOpPkg::CC_C]  = i_carry;                   // Meaningful for SUB
	end

endmodule

/* logic/aluFlowPkg.sv */
//--------------------------------------------------------------------------
// Handshake controller states of the ALU core
// One request in flight, four-phase req/ack
//--------------------------------------------------------------------------
package aluFlowPkg;

	// IDLE  waits for req, latches operands
	// EXEC  merge output gets registered, ack raised on exit
	// ACK   result held until req drops
	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_EXEC = 2'b01,
		ST_ACK  = 2'b10
	} hsState_e;

endpackage

/* logic/aluOpPkg.sv */
//--------------------------------------------------------------------------
// Opcode encoding and condition-code layout of the ALU
// Referenced by scoped name from the datapath units and the core
//--------------------------------------------------------------------------
package aluOpPkg;

	// 3-bit opcode, 0XX arithmetic/set/xor, 1XX shifts and logic
	typedef enum logic [2:0] {
		OP_ADD = 3'b000, // srcB + srcA
		OP_SUB = 3'b001, // srcB - srcA
		OP_SET = 3'b010, // Load immediate, optionally byte-shifted
		OP_XOR = 3'b011,
		OP_SLL = 3'b100, // srcA << srcB[3:0]
		OP_SRL = 3'b101, // srcA >> srcB[3:0], zero fill
		OP_OR  = 3'b110,
		OP_AND = 3'b111
	} aluOp_e;

	//----------------------------------------------------------------------
	// Bit positions inside the ccodes vector
	//----------------------------------------------------------------------
	localparam int CC_N = 3; // negative
	localparam int CC_Z = 2; // zero
	localparam int CC_P = 1; // Positive, inverse of sign bit
	localparam int CC_C = 0; // Adder carry-out

endpackage

/* logic/alu_cfg.svh */
//--------------------------------------------------------------------------
// Width settings for the 16-bit execution unit
// Include wherever a datapath or condition-code width is needed
//--------------------------------------------------------------------------
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width
`define ALU_DATA_W 16

// n, z, p, c
`define ALU_CC_W 4

// Low srcB bits used as the shift amount (0..15)
`define ALU_SHAMT_W 4

`endif

/* sim/AluCore_assertions.sv */
//--------------------------------------------------------------------------
// Handshake and reset properties of the ALU core
// Bound into every AluCore instance, failures are counted in failCount
// so the testbench can fold them into its summary
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module AluCore_assertions (
	input logic                    i_clk,
	input logic                    i_rstN,
	input logic                    i_req,
	input logic                    i_ack,     // o_ack of the core
	input logic [`ALU_DATA_W-1:0]  i_result   // o_result of the core
);

	int failCount = 0; // Read by the testbench

	// Async reset keeps ack low on every edge it covers
	ackLowInReset: assert property (@(posedge i_clk) !i_rstN |-> !i_ack)
		else begin
			$error("o_ack is high while reset is asserted");
			failCount++;
		end

	// Ack only answers a request
	ackNeedsReq: assert property (@(posedge i_clk) disable iff (!i_rstN)
		$rose(i_ack) |-> $past(i_req))
		else begin
			$error("o_ack rose without a pending i_req");
			failCount++;
		end

	// req first seen two edges before ack is seen, no earlier and no later
	ackLatency: assert property (@(posedge i_clk) disable iff (!i_rstN)
		$rose(i_ack) |-> ($past(i_req, 2) && !$past(i_req, 3)))
		else begin
			$error("o_ack did not rise two edges after i_req was accepted");
			failCount++;
		end

	// Result held for the whole ack phase
	resultHeld: assert property (@(posedge i_clk) disable iff (!i_rstN)
		(i_ack && $past(i_ack)) |-> $stable(i_result))
		else begin
			$error("o_result changed while o_ack was high");
			failCount++;
		end

endmodule

bind AluCore AluCore_assertions uAssertions (
	.i_clk    (i_clk),
	.i_rstN   (i_rstN),
	.i_req    (i_req),
	.i_ack    (o_ack),
	.i_result (o_result)
);

/* sim/AluCore_tb.sv */
//--------------------------------------------------------------------------
// Testbench of the ALU core
// Reads vectors from sim/alu_patterns.txt, runs each through the
// four-phase handshake and checks result, ccodes and ack timing
// Run from the project root so the pattern path resolves
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_cfg.svh"

module AluCore_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DLY    = 1;    // ns after the rising edge
	localparam int RESET_CYCLES = 5;
	localparam int ACK_LATENCY  = 2;    // req sampled, then result registered
	localparam int DROP_LATENCY = 1;    // Edge that sees req low clears ack
	localparam int WAIT_LIMIT   = 20;   // Cycles per wait before giving up
	localparam int HOLD_CYCLES  = 3;    // Back-pressure on every 5th vector

	logic                    clk;
	logic                    rstN;
	logic                    req;
	aluOpPkg::aluOp_e        opCode;
	logic                    opSel;
	logic [`ALU_DATA_W-1:0]  srcA;
	logic [`ALU_DATA_W-1:0]  srcB;
	logic                    ack;
	logic [`ALU_DATA_W-1:0]  result;
	logic [`ALU_CC_W-1:0]    ccodes;

	int errCount     = 0;
	int timeoutCount = 0;
	int vecCount     = 0;
	bit timedOut     = 1'b0;  // Stops the vector loop

	AluCore UUT (
		.i_clk    (clk),
		.i_rstN   (rstN),
		.i_req    (req),
		.i_opCode (opCode),
		.i_opSel  (opSel),
		.i_srcA   (srcA),
		.i_srcB   (srcB),
		.o_ack    (ack),
		.o_result (result),
		.o_ccodes (ccodes)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			errCount++;
		end
	endtask

	// Steps edge by edge until ack reaches level, sampling just after the edge
	task automatic waitAck(input logic level, input string what, output int edges);
		edges = 0;
		while (ack !== level && edges < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DLY;
			edges++;
		end
		if (ack !== level) begin
			$display("Timeout: %s did not happen within %0d clock cycles", what, WAIT_LIMIT);
			timeoutCount++;
			timedOut = 1'b1;
		end
	endtask

	// One full four-phase transaction, called just after a rising edge
	task automatic runVector(input logic [2:0] op, input logic sel,
			input logic [`ALU_DATA_W-1:0] a, input logic [`ALU_DATA_W-1:0] b,
			input logic [`ALU_DATA_W-1:0] expRes, input logic [`ALU_CC_W-1:0] expCc,
			input int holdCycles);
		int edges;
		string tag;
		tag    = $sformatf("vector %0d", vecCount);
		opCode = aluOpPkg::aluOp_e'(op);
		opSel  = sel;
		srcA   = a;
		srcB   = b;
		req    = 1'b1;
		waitAck(1'b1, {tag, " o_ack rise"}, edges);
		if (timedOut) return;
		checkValue(edges, ACK_LATENCY, {tag, " ack latency"});
		checkValue({16'h0, result}, {16'h0, expRes}, {tag, " result"});
		checkValue({28'h0, ccodes}, {28'h0, expCc}, {tag, " ccodes"});
		// Requester stalls, core must keep ack and data
		repeat (holdCycles) begin
			@(posedge clk);
			#DRIVE_DLY;
			checkValue({31'h0, ack}, 32'h1, {tag, " ack during hold"});
			checkValue({16'h0, result}, {16'h0, expRes}, {tag, " result during hold"});
			checkValue({28'h0, ccodes}, {28'h0, expCc}, {tag, " ccodes during hold"});
		end
		req = 1'b0;
		waitAck(1'b0, {tag, " o_ack fall"}, edges);
		if (timedOut) return;
		checkValue(edges, DROP_LATENCY, {tag, " ack release latency"});
	endtask

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------

	initial begin
		int fd;
		int fields;
		int assertFails;
		string line;
		logic [31:0] fOp, fSel, fA, fB, fRes, fCc;
		rstN   = 1'b0;
		req    = 1'b0;
		opCode = aluOpPkg::OP_ADD;
		opSel  = 1'b0;
		srcA   = '0;
		srcB   = '0;
		fd = $fopen("sim/alu_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file sim/alu_patterns.txt");
			errCount++;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rstN = 1'b1;
		// No edge since release, response side still at its reset values
		checkValue({31'h0, ack}, 32'h0, "ack after reset");
		checkValue({16'h0, result}, 32'h0, "result after reset");
		checkValue({28'h0, ccodes}, 32'h0, "ccodes after reset");
		if (fd != 0) begin
			// Comment and blank lines scan zero fields and are skipped
			while (!timedOut && $fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%h %h %h %h %h %h", fOp, fSel, fA, fB, fRes, fCc);
				if (fields == 6) begin
					runVector(fOp[2:0], fSel[0], fA[15:0], fB[15:0], fRes[15:0], fCc[3:0],
						(vecCount % 5 == 4) ? HOLD_CYCLES : 0);
					vecCount++;
				end
			end
			$fclose(fd);
		end
		if (vecCount == 0) begin
			$display("No test vectors were run");
			errCount++;
		end
		assertFails = UUT.uAssertions.failCount;
		$display("Vectors: %0d  value errors: %0d  timeouts: %0d  assertion failures: %0d",
			vecCount, errCount, timeoutCount, assertFails);
		if (errCount == 0 && timeoutCount == 0 && assertFails == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* sim/alu_patterns.txt */
// Columns in hex: opcode opSel srcA srcB expResult expCcodes
// Ccodes nibble is n z p c, c from srcB + (srcA or ~srcA+1 on odd opcodes)
// ADD
0 0 0001 0002 0003 2
0 0 7fff 0001 8000 8
0 0 ffff 0001 0000 7
0 0 8000 8000 0000 7
0 0 1234 4321 5555 2
0 0 f000 2000 1000 3
0 0 0000 0000 0000 6
0 0 abcd 1111 bcde 8
// SUB
1 0 0001 0003 0002 3
1 0 0003 0001 fffe 8
1 0 1234 1234 0000 7
1 0 0001 8000 7fff 3
1 0 ffff 0000 0001 2
1 0 0000 0000 0000 7
1 0 1000 9000 8000 9
1 0 5555 2222 cccd 8
// SET
2 0 0000 1234 1234 2
2 0 ffff 8001 8001 9
2 0 0001 0000 0000 6
2 0 f000 1000 1000 3
2 1 00ab 00cd abcd 8
2 1 ff12 3434 1234 3
2 1 0000 ff00 0000 6
2 1 127f 5a66 7f66 2
// XOR
3 0 ff00 0ff0 f0f0 8
3 0 1234 1234 0000 7
3 0 0f0f f0f0 ffff 9
3 0 0001 0003 0002 3
3 0 aaaa 0000 aaaa 8
// SLL
4 0 0001 0000 0001 2
4 0 0001 000f 8000 8
4 0 1234 0004 2340 2
4 0 8001 0001 0002 2
4 0 00ff fff8 ff00 9
4 0 ffff 0010 ffff 9
4 0 0003 000f 8000 8
4 0 8000 0001 0000 6
// SRL
5 0 8000 000f 0001 2
5 0 8000 0000 8000 8
5 0 1234 0004 0123 2
5 0 0001 0001 0000 7
5 0 f0f0 fff4 0f0f 3
5 0 0002 0011 0001 3
5 0 ffff 0008 00ff 2
// OR
6 0 0000 0000 0000 6
6 0 f000 0f00 ff00 8
6 0 8000 8000 8000 9
6 0 1234 0101 1335 2
6 0 ffff 0001 ffff 9
// AND
7 0 ffff ffff ffff 9
7 0 f0f0 0f0f 0000 6
7 0 1234 00ff 0034 2
7 0 0001 8001 0001 3
7 0 8000 c000 8000 9
7 0 0000 0000 0000 7

/* src.f */
+incdir+logic
logic/aluOpPkg.sv
logic/aluFlowPkg.sv
logic/AdderSetUnit.sv
logic/BitwiseUnit.sv
logic/ResultMerge.sv
logic/AluCore.sv
sim/AluCore_assertions.sv
sim/AluCore_tb.sv
